//--- common/bp_pkg.sv
`default_nettype none

package bp_pkg;

    localparam int FETCH_WIDTH  = 2;
    localparam int HISTORY_BITS = 4;
    localparam int BTB_ENTRIES  = 16;
    localparam int PHT_ENTRIES  = 16;
    localparam int RAS_DEPTH    = 4;

    localparam int BTB_IDX_BITS = $clog2(BTB_ENTRIES);
    localparam int BTB_TAG_BITS = 32 - 2 - BTB_IDX_BITS;  // PC above the index bits
    localparam int PHT_IDX_BITS = $clog2(PHT_ENTRIES);
    localparam int RAS_PTR_BITS = $clog2(RAS_DEPTH);

    localparam logic [1:0] CTR_WEAK_NT = 2'b01;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef logic [31:0] addr_t;

    // One instruction word seen as I-format or J-format
    typedef union packed {
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic        imm_20;
            logic [9:0]  imm_10_1;
            logic        imm_11;
            logic [7:0]  imm_19_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } j;
    } inst_t;

    // Two-bit saturating counter step
    function automatic logic [1:0] ctr_next(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'd1;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'd1;
    endfunction

endpackage

`default_nettype wire

//--- common/bp_update_if.sv
`timescale 1ns/1ps
`default_nettype none

// Execute-stage resolution, one entry per slot
interface bp_update_if;
    logic [bp_pkg::FETCH_WIDTH-1:0]                         ex_valid;
    logic [bp_pkg::FETCH_WIDTH-1:0]                         taken;
    bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]                branch_pc;
    bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]                target_pc;
    logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::HISTORY_BITS-1:0] history;  // As sent at fetch
    logic [bp_pkg::FETCH_WIDTH-1:0]                         gshare_pred;
    logic [bp_pkg::FETCH_WIDTH-1:0]                         bi_pred;

    modport src (
        output ex_valid, taken, branch_pc, target_pc, history, gshare_pred, bi_pred
    );

    modport sink (
        input ex_valid, taken, branch_pc, target_pc, history, gshare_pred, bi_pred
    );
endinterface

`default_nettype wire

//--- direction/bimodal.sv
`timescale 1ns/1ps
`default_nettype none

module bimodal (
    input  logic                                    clock,
    input  logic                                    rst_n_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] if_pc_i,
    bp_update_if.sink                               upd,
    output logic [bp_pkg::FETCH_WIDTH-1:0]          pred_o
);
    logic [1:0] pht [bp_pkg::PHT_ENTRIES];

    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            pred_o[s] = pht[if_pc_i[s][bp_pkg::PHT_IDX_BITS+1:2]][1];  // Upper bit is taken
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int e = 0; e < bp_pkg::PHT_ENTRIES; e++) begin
                pht[e] <= bp_pkg::CTR_WEAK_NT;
            end
        end else begin
            for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
                if (upd.ex_valid[s]) begin
                    pht[upd.branch_pc[s][bp_pkg::PHT_IDX_BITS+1:2]] <= bp_pkg::ctr_next(
                        pht[upd.branch_pc[s][bp_pkg::PHT_IDX_BITS+1:2]], upd.taken[s]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- direction/gshare.sv
`timescale 1ns/1ps
`default_nettype none

module gshare (
    input  logic                                    clock,
    input  logic                                    rst_n_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] if_pc_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]          cond_branch_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]          sel_pred_i,
    bp_update_if.sink                               upd,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]          mispredict_i,
    output logic [bp_pkg::FETCH_WIDTH-1:0]          pred_o,
    output logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::HISTORY_BITS-1:0] history_o
);
    logic [1:0]                      pht [bp_pkg::PHT_ENTRIES];
    logic [bp_pkg::HISTORY_BITS-1:0] ghr, ghr_next;
    logic [bp_pkg::PHT_IDX_BITS-1:0] upd_idx [bp_pkg::FETCH_WIDTH];

    // History as each slot sees it, then as it leaves the group
    always_comb begin
        ghr_next = ghr;
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            history_o[s] = ghr_next;
            pred_o[s]    = pht[if_pc_i[s][bp_pkg::PHT_IDX_BITS+1:2]
                               ^ ghr_next[bp_pkg::PHT_IDX_BITS-1:0]][1];
            if (cond_branch_i[s]) begin
                ghr_next = {ghr_next[bp_pkg::HISTORY_BITS-2:0], sel_pred_i[s]};
            end
        end
    end

    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            upd_idx[s] = upd.branch_pc[s][bp_pkg::PHT_IDX_BITS+1:2]
                       ^ upd.history[s][bp_pkg::PHT_IDX_BITS-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            ghr <= '0;
            for (int e = 0; e < bp_pkg::PHT_ENTRIES; e++) begin
                pht[e] <= bp_pkg::CTR_WEAK_NT;
            end
        end else begin
            ghr <= ghr_next;
            // Restore from the lowest mispredicting slot
            for (int s = bp_pkg::FETCH_WIDTH - 1; s >= 0; s--) begin
                if (upd.ex_valid[s] && mispredict_i[s]) begin
                    ghr <= {upd.history[s][bp_pkg::HISTORY_BITS-2:0], upd.taken[s]};
                end
            end
            for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
                if (upd.ex_valid[s]) begin
                    pht[upd_idx[s]] <= bp_pkg::ctr_next(pht[upd_idx[s]], upd.taken[s]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- direction/predictor_selector.sv
`timescale 1ns/1ps
`default_nettype none

module predictor_selector (
    input  logic                                    clock,
    input  logic                                    rst_n_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] if_pc_i,
    bp_update_if.sink                               upd,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]          gshare_correct_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]          bimodal_correct_i,
    output logic [bp_pkg::FETCH_WIDTH-1:0]          use_gshare_o
);
    logic [1:0] chooser [bp_pkg::PHT_ENTRIES];  // High half prefers gshare

    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            use_gshare_o[s] = chooser[if_pc_i[s][bp_pkg::PHT_IDX_BITS+1:2]][1];
        end
    end

    // Trains only when the two predictors disagree on correctness
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            for (int e = 0; e < bp_pkg::PHT_ENTRIES; e++) begin
                chooser[e] <= bp_pkg::CTR_WEAK_NT;
            end
        end else begin
            for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
                if (upd.ex_valid[s] && (gshare_correct_i[s] != bimodal_correct_i[s])) begin
                    chooser[upd.branch_pc[s][bp_pkg::PHT_IDX_BITS+1:2]] <= bp_pkg::ctr_next(
                        chooser[upd.branch_pc[s][bp_pkg::PHT_IDX_BITS+1:2]],
                        gshare_correct_i[s]);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  logic                                               clock,
    input  logic                                               rst_n_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]            if_pc_i,
    input  bp_pkg::inst_t [bp_pkg::FETCH_WIDTH-1:0]            inst_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                     if_valid_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                     ex_is_branch_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                     ex_taken_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]            ex_branch_pc_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]            ex_target_pc_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::HISTORY_BITS-1:0] ex_history_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                     ex_gshare_pred_i,
    input  logic [bp_pkg::FETCH_WIDTH-1:0]                     ex_bi_pred_i,
    output bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0]            next_pc_o,
    output logic                                               take_branch_o,
    output logic [bp_pkg::FETCH_WIDTH-1:0]                     gshare_pred_o,
    output logic [bp_pkg::FETCH_WIDTH-1:0]                     bi_pred_o,
    output logic [bp_pkg::FETCH_WIDTH-1:0][bp_pkg::HISTORY_BITS-1:0] history_o
);
    logic [bp_pkg::FETCH_WIDTH-1:0] cond_branch, jump, call, ret;
    logic [bp_pkg::FETCH_WIDTH-1:0] btb_hit;
    bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] btb_target;
    logic [bp_pkg::FETCH_WIDTH-1:0] use_gshare, pred_taken;
    logic [bp_pkg::FETCH_WIDTH-1:0] branch_req, branch_gnt, jump_gnt, call_gnt, ret_gnt;
    logic [bp_pkg::FETCH_WIDTH-1:0] gshare_correct, bimodal_correct, gshare_mispred;
    logic ras_push, ras_pop;
    bp_pkg::addr_t link_pc, ras_top;

    bp_update_if upd ();

    // Lowest requesting slot wins
    function automatic logic [bp_pkg::FETCH_WIDTH-1:0] first_slot(
        input logic [bp_pkg::FETCH_WIDTH-1:0] req
    );
        logic [bp_pkg::FETCH_WIDTH-1:0] gnt;
        logic found;
        gnt   = '0;
        found = 1'b0;
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            if (req[s] && !found) begin
                gnt[s] = 1'b1;
                found  = 1'b1;
            end
        end
        return gnt;
    endfunction

    assign upd.ex_valid    = ex_is_branch_i;
    assign upd.taken       = ex_taken_i;
    assign upd.branch_pc   = ex_branch_pc_i;
    assign upd.target_pc   = ex_target_pc_i;
    assign upd.history     = ex_history_i;
    assign upd.gshare_pred = ex_gshare_pred_i;
    assign upd.bi_pred     = ex_bi_pred_i;

    assign gshare_correct  = ~(upd.gshare_pred ^ upd.taken);
    assign bimodal_correct = ~(upd.bi_pred ^ upd.taken);
    assign gshare_mispred  = upd.ex_valid & ~gshare_correct;

    assign pred_taken = (use_gshare & gshare_pred_o) | (~use_gshare & bi_pred_o);

    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            branch_req[s] = ret[s]
                          || ((jump[s] || call[s]) && btb_hit[s])
                          || (cond_branch[s] && btb_hit[s] && pred_taken[s]);
        end
    end

    assign branch_gnt    = first_slot(branch_req);
    assign jump_gnt      = first_slot(jump | call);
    assign call_gnt      = first_slot(call);
    assign ret_gnt       = first_slot(ret);
    assign take_branch_o = rst_n_i && (|branch_gnt);  // Quiet in reset

    // Return stack control
    assign ras_push = |call_gnt;
    assign ras_pop  = |ret_gnt;

    always_comb begin
        link_pc = '0;
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            if (call_gnt[s]) link_pc = if_pc_i[s] + 32'd4;
        end
    end

    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            next_pc_o[s] = if_pc_i[s] + 32'd4;
            if (ret_gnt[s]) begin
                next_pc_o[s] = ras_top;
            end else if (if_valid_i[s] && btb_hit[s] && (pred_taken[s] || jump_gnt[s])) begin
                next_pc_o[s] = btb_target[s];
            end
        end
    end

    for (genvar s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin : g_decode
        pre_decoder u_pre_decoder (
            .inst_i       (inst_i[s]),
            .valid_i      (if_valid_i[s]),
            .cond_branch_o(cond_branch[s]),
            .jump_o       (jump[s]),
            .call_o       (call[s]),
            .ret_o        (ret[s])
        );
    end

    btb u_btb (
        .clock   (clock),
        .rst_n_i (rst_n_i),
        .if_pc_i (if_pc_i),
        .upd     (upd.sink),
        .hit_o   (btb_hit),
        .target_o(btb_target)
    );

    gshare u_gshare (
        .clock        (clock),
        .rst_n_i      (rst_n_i),
        .if_pc_i      (if_pc_i),
        .cond_branch_i(cond_branch),
        .sel_pred_i   (pred_taken),
        .upd          (upd.sink),
        .mispredict_i (gshare_mispred),
        .pred_o       (gshare_pred_o),
        .history_o    (history_o)
    );

    bimodal u_bimodal (
        .clock  (clock),
        .rst_n_i(rst_n_i),
        .if_pc_i(if_pc_i),
        .upd    (upd.sink),
        .pred_o (bi_pred_o)
    );

    predictor_selector u_selector (
        .clock            (clock),
        .rst_n_i          (rst_n_i),
        .if_pc_i          (if_pc_i),
        .upd              (upd.sink),
        .gshare_correct_i (gshare_correct),
        .bimodal_correct_i(bimodal_correct),
        .use_gshare_o     (use_gshare)
    );

    ras u_ras (
        .clock    (clock),
        .rst_n_i  (rst_n_i),
        .push_i   (ras_push),
        .pop_i    (ras_pop),
        .link_pc_i(link_pc),
        .top_o    (ras_top)
    );

endmodule

`default_nettype wire

//--- hdl/btb.sv
`timescale 1ns/1ps
`default_nettype none

module btb (
    input  logic                                    clock,
    input  logic                                    rst_n_i,
    input  bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] if_pc_i,
    bp_update_if.sink                               upd,
    output logic [bp_pkg::FETCH_WIDTH-1:0]          hit_o,
    output bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] target_o
);
    logic [bp_pkg::BTB_ENTRIES-1:0]  valid;
    logic [bp_pkg::BTB_TAG_BITS-1:0] tag    [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t                   target [bp_pkg::BTB_ENTRIES];

    // Two read ports
    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            hit_o[s] = valid[if_pc_i[s][bp_pkg::BTB_IDX_BITS+1:2]]
                    && (tag[if_pc_i[s][bp_pkg::BTB_IDX_BITS+1:2]]
                        == if_pc_i[s][31:bp_pkg::BTB_IDX_BITS+2]);
            target_o[s] = target[if_pc_i[s][bp_pkg::BTB_IDX_BITS+1:2]];
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            valid <= '0;
        end else begin
            for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
                if (upd.ex_valid[s] && upd.taken[s]) begin
                    valid[upd.branch_pc[s][bp_pkg::BTB_IDX_BITS+1:2]] <= 1'b1;
                end
            end
        end
    end

    // Later slot overwrites on a shared index
    always_ff @(posedge clock) begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            if (upd.ex_valid[s] && upd.taken[s]) begin
                tag[upd.branch_pc[s][bp_pkg::BTB_IDX_BITS+1:2]] <=
                    upd.branch_pc[s][31:bp_pkg::BTB_IDX_BITS+2];
                target[upd.branch_pc[s][bp_pkg::BTB_IDX_BITS+1:2]] <= upd.target_pc[s];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/pre_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module pre_decoder (
    input  bp_pkg::inst_t inst_i,
    input  logic          valid_i,
    output logic          cond_branch_o,
    output logic          jump_o,
    output logic          call_o,
    output logic          ret_o
);
    logic is_jal, link_ra, is_ret;

    assign is_jal  = inst_i.j.opcode == bp_pkg::OPC_JAL;
    assign link_ra = inst_i.j.rd == 5'd1;  // ra

    // jalr x0, 0(ra)
    assign is_ret = (inst_i.i.opcode == bp_pkg::OPC_JALR)
                 && (inst_i.i.funct3 == 3'd0)
                 && (inst_i.i.rd == 5'd0)
                 && (inst_i.i.rs1 == 5'd1)
                 && (inst_i.i.imm == 12'd0);

    assign cond_branch_o = valid_i && (inst_i.i.opcode == bp_pkg::OPC_BRANCH);
    assign jump_o        = valid_i && is_jal && !link_ra;
    assign call_o        = valid_i && is_jal && link_ra;
    assign ret_o         = valid_i && is_ret;

endmodule

`default_nettype wire

//--- hdl/ras.sv
`timescale 1ns/1ps
`default_nettype none

module ras (
    input  logic          clock,
    input  logic          rst_n_i,
    input  logic          push_i,
    input  logic          pop_i,
    input  bp_pkg::addr_t link_pc_i,
    output bp_pkg::addr_t top_o
);
    logic [bp_pkg::RAS_PTR_BITS-1:0] ptr;      // Next free entry
    logic [bp_pkg::RAS_PTR_BITS-1:0] top_ptr;
    bp_pkg::addr_t                   stack [bp_pkg::RAS_DEPTH];

    assign top_ptr = ptr - 1'b1;
    assign top_o   = stack[top_ptr];

    // Pointer wraps, so a full stack loses its oldest entry
    always_ff @(posedge clock) begin
        if (!rst_n_i) begin
            ptr <= '0;
            for (int e = 0; e < bp_pkg::RAS_DEPTH; e++) begin
                stack[e] <= '0;
            end
        end else if (push_i && pop_i) begin
            stack[top_ptr] <= link_pc_i;  // Replace top
        end else if (push_i) begin
            stack[ptr] <= link_pc_i;
            ptr        <= ptr + 1'b1;
        end else if (pop_i) begin
            ptr <= top_ptr;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f --top-module tb_branch_predictor -o tb_sim

output=$(./obj_dir/tb_sim)
echo "$output"

if grep -qx "Everything OK" <<< "$output"; then
    exit 0
fi
exit 1

//--- sources.f
common/bp_pkg.sv
common/bp_update_if.sv
hdl/pre_decoder.sv
hdl/btb.sv
hdl/ras.sv
direction/gshare.sv
direction/bimodal.sv
direction/predictor_selector.sv
hdl/branch_predictor.sv
testbench/bp_checker.sv
testbench/tb_branch_predictor.sv

//--- testbench/bp_checker.sv
`timescale 1ns/1ps
`default_nettype none

module bp_checker (
    input logic                                    clock,
    input logic                                    rst_n_i,
    input bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] if_pc_i,
    input bp_pkg::inst_t [bp_pkg::FETCH_WIDTH-1:0] inst_i,
    input logic [bp_pkg::FETCH_WIDTH-1:0]          if_valid_i,
    input bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] next_pc_i,
    input logic                                    take_branch_i,
    input logic                                    push_i,
    input logic                                    pop_i
);
    logic [bp_pkg::FETCH_WIDTH-1:0] call_seen, ret_seen;

    // Calls and returns decoded from the raw fetch words
    always_comb begin
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            call_seen[s] = if_valid_i[s] && (inst_i[s][6:0] == bp_pkg::OPC_JAL)
                        && (inst_i[s][11:7] == 5'd1);
            ret_seen[s]  = if_valid_i[s] && (inst_i[s] == 32'h0000_8067);
        end
    end

    quiet_in_reset: assert property (@(posedge clock) !rst_n_i |-> !take_branch_i)
        else $error("take_branch_o high during reset");

    for (genvar s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin : g_slot
        // An invalid slot falls through
        invalid_gets_pc4: assert property (@(posedge clock) disable iff (!rst_n_i)
            !if_valid_i[s] |-> next_pc_i[s] == if_pc_i[s] + 32'd4)
            else $error("slot %0d without valid did not get PC+4", s);
    end

    push_pop_source: assert property (@(posedge clock) disable iff (!rst_n_i)
        (push_i && pop_i) |-> (|call_seen && |ret_seen))
        else $error("RAS push and pop together without a call and a return");

endmodule

bind branch_predictor bp_checker u_checker (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .if_pc_i      (if_pc_i),
    .inst_i       (inst_i),
    .if_valid_i   (if_valid_i),
    .next_pc_i    (next_pc_o),
    .take_branch_i(take_branch_o),
    .push_i       (ras_push),
    .pop_i        (ras_pop)
);

`default_nettype wire

//--- testbench/tb_branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

module tb_branch_predictor;
    logic clock = 1'b0;
    logic rst_n_i;
    bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] if_pc_i, ex_branch_pc_i, ex_target_pc_i, next_pc_o;
    bp_pkg::inst_t [bp_pkg::FETCH_WIDTH-1:0] inst_i;
    logic [bp_pkg::FETCH_WIDTH-1:0] if_valid_i, ex_is_branch_i, ex_taken_i;
    logic [bp_pkg::FETCH_WIDTH-1:0] ex_gshare_pred_i, ex_bi_pred_i, gshare_pred_o, bi_pred_o;
    logic [bp_pkg::FETCH_WIDTH-1:0][3:0] ex_history_i, history_o;
    logic take_branch_o;

    // Reference model state
    logic          m_btb_valid  [bp_pkg::BTB_ENTRIES];
    logic [25:0]   m_btb_tag    [bp_pkg::BTB_ENTRIES];
    bp_pkg::addr_t m_btb_target [bp_pkg::BTB_ENTRIES];
    logic [1:0]    m_gs [bp_pkg::PHT_ENTRIES];
    logic [1:0]    m_bi [bp_pkg::PHT_ENTRIES];
    logic [1:0]    m_sel [bp_pkg::PHT_ENTRIES];
    bp_pkg::addr_t m_ras [bp_pkg::RAS_DEPTH];
    logic [1:0]    m_ras_ptr;
    logic [3:0]    m_ghr, spec_ghr;  // Committed and after this group
    logic          m_push, m_pop;
    bp_pkg::addr_t m_link;

    bp_pkg::addr_t [bp_pkg::FETCH_WIDTH-1:0] exp_next_pc;
    logic [bp_pkg::FETCH_WIDTH-1:0] exp_gs, exp_bi;
    logic [bp_pkg::FETCH_WIDTH-1:0][3:0] exp_hist;
    logic exp_take;

    int errors = 0;
    int redirects = 0;
    int random_cycles = 400;

    branch_predictor DUT (.*);

    always #10 clock = ~clock;

    function automatic logic [1:0] counter_step(input logic [1:0] c, input logic up);
        if (up && c != 2'b11) return c + 2'd1;
        if (!up && c != 2'b00) return c - 2'd1;
        return c;
    endfunction

    function automatic void reset_model();
        for (int e = 0; e < bp_pkg::PHT_ENTRIES; e++) begin
            m_btb_valid[e]  = 1'b0;
            m_btb_tag[e]    = '0;
            m_btb_target[e] = '0;
            m_gs[e]         = bp_pkg::CTR_WEAK_NT;
            m_bi[e]         = bp_pkg::CTR_WEAK_NT;
            m_sel[e]        = bp_pkg::CTR_WEAK_NT;
        end
        for (int e = 0; e < bp_pkg::RAS_DEPTH; e++) begin
            m_ras[e] = '0;
        end
        m_ras_ptr = '0;
        m_ghr     = '0;
    endfunction

    // Expected outputs for the group on the fetch inputs
    function automatic void predict_model();
        logic [3:0] h, idx;
        logic [31:0] w;
        logic cond, jmp, call, ret, hit, guess, jump_seen, ret_seen;
        h         = m_ghr;
        jump_seen = 1'b0;
        ret_seen  = 1'b0;
        m_push    = 1'b0;
        m_link    = '0;
        exp_take  = 1'b0;
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            w    = inst_i[s];
            cond = if_valid_i[s] && w[6:0] == bp_pkg::OPC_BRANCH;
            jmp  = if_valid_i[s] && w[6:0] == bp_pkg::OPC_JAL;  // Calls too
            call = jmp && w[11:7] == 5'd1;
            ret  = if_valid_i[s] && w == 32'h0000_8067;  // jalr x0, 0(ra)
            idx  = if_pc_i[s][5:2];
            hit  = m_btb_valid[idx] && m_btb_tag[idx] == if_pc_i[s][31:6];
            exp_hist[s] = h;
            exp_gs[s]   = m_gs[idx ^ h][1];
            exp_bi[s]   = m_bi[idx][1];
            guess       = m_sel[idx][1] ? exp_gs[s] : exp_bi[s];
            if (cond) h = {h[2:0], guess};
            exp_take |= ret || (jmp && hit) || (cond && hit && guess);
            exp_next_pc[s] = if_pc_i[s] + 32'd4;
            if (ret && !ret_seen) begin
                exp_next_pc[s] = m_ras[m_ras_ptr - 2'd1];
            end else if (if_valid_i[s] && hit && (guess || (jmp && !jump_seen))) begin
                exp_next_pc[s] = m_btb_target[idx];
            end
            if (ret) ret_seen = 1'b1;
            if (jmp) jump_seen = 1'b1;
            if (call && !m_push) begin
                m_push = 1'b1;
                m_link = if_pc_i[s] + 32'd4;
            end
        end
        m_pop    = ret_seen;
        spec_ghr = h;
    endfunction

    // State change at the rising edge
    function automatic void train_model();
        logic [3:0] gi [2];
        logic [3:0] pi [2];
        logic [1:0] gs_new [2];
        logic [1:0] bi_new [2];
        logic [1:0] sel_new [2];
        logic [1:0] sel_en;
        logic gs_ok, bi_ok;
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            pi[s]      = ex_branch_pc_i[s][5:2];
            gi[s]      = pi[s] ^ ex_history_i[s];
            gs_ok      = ex_gshare_pred_i[s] == ex_taken_i[s];
            bi_ok      = ex_bi_pred_i[s] == ex_taken_i[s];
            sel_en[s]  = gs_ok != bi_ok;
            gs_new[s]  = counter_step(m_gs[gi[s]], ex_taken_i[s]);
            bi_new[s]  = counter_step(m_bi[pi[s]], ex_taken_i[s]);
            sel_new[s] = counter_step(m_sel[pi[s]], gs_ok);
        end
        m_ghr = spec_ghr;
        for (int s = bp_pkg::FETCH_WIDTH - 1; s >= 0; s--) begin
            if (ex_is_branch_i[s] && ex_gshare_pred_i[s] != ex_taken_i[s]) begin
                m_ghr = {ex_history_i[s][2:0], ex_taken_i[s]};
            end
        end
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            if (ex_is_branch_i[s]) begin
                m_gs[gi[s]] = gs_new[s];
                m_bi[pi[s]] = bi_new[s];
                if (sel_en[s]) m_sel[pi[s]] = sel_new[s];
                if (ex_taken_i[s]) begin
                    m_btb_valid[pi[s]]  = 1'b1;
                    m_btb_tag[pi[s]]    = ex_branch_pc_i[s][31:6];
                    m_btb_target[pi[s]] = ex_target_pc_i[s];
                end
            end
        end
        if (m_push && m_pop) begin
            m_ras[m_ras_ptr - 2'd1] = m_link;
        end else if (m_push) begin
            m_ras[m_ras_ptr] = m_link;
            m_ras_ptr        = m_ras_ptr + 2'd1;
        end else if (m_pop) begin
            m_ras_ptr = m_ras_ptr - 2'd1;
        end
    endfunction

    function automatic void report_mismatch(input string name, input logic [31:0] expected,
                                            input logic [31:0] actual);
        errors++;
        $display("Fail %0t ns %s expected %h got %h", $time, name, expected, actual);
    endfunction

    task automatic check_outputs();
        assert (take_branch_o === exp_take)
            else report_mismatch("take_branch_o", 32'(exp_take), 32'(take_branch_o));
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            assert (next_pc_o[s] === exp_next_pc[s])
                else report_mismatch($sformatf("next_pc_o[%0d]", s), exp_next_pc[s], next_pc_o[s]);
            assert (gshare_pred_o[s] === exp_gs[s]) else report_mismatch(
                $sformatf("gshare_pred_o[%0d]", s), 32'(exp_gs[s]), 32'(gshare_pred_o[s]));
            assert (bi_pred_o[s] === exp_bi[s]) else report_mismatch(
                $sformatf("bi_pred_o[%0d]", s), 32'(exp_bi[s]), 32'(bi_pred_o[s]));
            assert (history_o[s] === exp_hist[s]) else report_mismatch(
                $sformatf("history_o[%0d]", s), 32'(exp_hist[s]), 32'(history_o[s]));
        end
        if (take_branch_o === 1'b1) redirects++;
    endtask

    // Compare just before each rising edge, then step the model
    always begin
        @(negedge clock);
        #9;
        if (rst_n_i) begin
            predict_model();
            check_outputs();
            train_model();
        end
    end

    task automatic fetch_pair(input bp_pkg::addr_t pc0, input logic [31:0] w0,
                              input logic [31:0] w1, input logic [1:0] valid);
        @(negedge clock);
        if_pc_i[0]     = pc0;
        if_pc_i[1]     = pc0 + 32'd4;
        inst_i[0]      = w0;
        inst_i[1]      = w1;
        if_valid_i     = valid;
        ex_is_branch_i = 2'b00;
    endtask

    // Slot 0 resolution with no fetch
    task automatic resolve(input bp_pkg::addr_t pc, input bp_pkg::addr_t target,
                           input logic taken, input logic [3:0] hist,
                           input logic gs, input logic bi);
        @(negedge clock);
        if_valid_i          = 2'b00;
        ex_is_branch_i      = 2'b01;
        ex_taken_i[0]       = taken;
        ex_branch_pc_i[0]   = pc;
        ex_target_pc_i[0]   = target;
        ex_history_i[0]     = hist;
        ex_gshare_pred_i[0] = gs;
        ex_bi_pred_i[0]     = bi;
    endtask

    function automatic logic [31:0] random_word();
        logic [31:0] r;
        r = $urandom;
        case (r[2:0] % 3'd5)
            3'd0: return 32'h0000_0013;
            3'd1: return {r[31:7], bp_pkg::OPC_BRANCH};
            3'd2: return {r[31:12], 5'd0, bp_pkg::OPC_JAL};
            3'd3: return {r[31:12], 5'd1, bp_pkg::OPC_JAL};
            default: return 32'h0000_8067;
        endcase
    endfunction

    task automatic random_cycle();
        logic [31:0] r;
        @(negedge clock);
        r          = $urandom;
        if_pc_i[0] = {24'h000010, r[7:2], 2'b00};  // 64 words, four tags per index
        if_pc_i[1] = if_pc_i[0] + 32'd4;
        inst_i[0]  = random_word();
        inst_i[1]  = random_word();
        if_valid_i = r[9:8];
        for (int s = 0; s < bp_pkg::FETCH_WIDTH; s++) begin
            r                   = $urandom;
            ex_is_branch_i[s]   = r[0];
            ex_taken_i[s]       = r[1];
            ex_gshare_pred_i[s] = r[2];
            ex_bi_pred_i[s]     = r[3];
            ex_history_i[s]     = r[7:4];
            ex_branch_pc_i[s]   = {24'h000010, r[13:8], 2'b00};
            ex_target_pc_i[s]   = {16'h0000, r[31:18], 2'b00};
        end
    endtask

    initial begin
        #((8 + 60 + random_cycles) * 20 + 500);
        $display("Watchdog expired before the stimulus finished");
        $display("Something failed");
        $finish;
    end

    initial begin
        void'($urandom(32'he5dd8e7a));
        rst_n_i          = 1'b0;
        if_pc_i          = '0;
        inst_i           = '0;
        inst_i[0]        = 32'h0000_8067;  // Return fetched while in reset
        if_valid_i       = 2'b01;
        ex_is_branch_i   = '0;
        ex_taken_i       = '0;
        ex_branch_pc_i   = '0;
        ex_target_pc_i   = '0;
        ex_history_i     = '0;
        ex_gshare_pred_i = '0;
        ex_bi_pred_i     = '0;
        reset_model();
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n_i    = 1'b1;
        if_valid_i = '0;
        // Empty tables, slot 1 return not valid
        fetch_pair(32'h0000_0100, 32'h0000_006f, 32'h0000_0063, 2'b11);
        fetch_pair(32'h0000_0200, 32'h0000_00ef, 32'h0000_0013, 2'b11);
        fetch_pair(32'h0000_0300, 32'h0000_006f, 32'h0000_8067, 2'b01);
        // jal target, then an alias with another tag
        resolve(32'h0000_0100, 32'h0000_0800, 1'b1, 4'h0, 1'b0, 1'b0);
        fetch_pair(32'h0000_0100, 32'h0000_006f, 32'h0000_0013, 2'b11);
        fetch_pair(32'h0000_0140, 32'h0000_006f, 32'h0000_0013, 2'b11);
        // Bimodal flips on a branch in slot 1
        repeat (2) resolve(32'h0000_0208, 32'h0000_0a00, 1'b1, 4'h0, 1'b0, 1'b0);
        fetch_pair(32'h0000_0204, 32'h0000_0013, 32'h0000_0063, 2'b11);
        repeat (2) resolve(32'h0000_0208, 32'h0000_0a00, 1'b0, 4'h0, 1'b0, 1'b0);
        fetch_pair(32'h0000_0204, 32'h0000_0013, 32'h0000_0063, 2'b11);
        // Nested calls, then returns
        for (int i = 0; i < bp_pkg::RAS_DEPTH; i++) begin
            fetch_pair(bp_pkg::addr_t'(32'h1000 + 256 * i), 32'h0000_00ef, 32'h0000_0013, 2'b01);
        end
        for (int i = 0; i < bp_pkg::RAS_DEPTH; i++) begin
            fetch_pair(bp_pkg::addr_t'(32'h2000 + 16 * i), 32'h0000_8067, 32'h0000_0013, 2'b01);
        end
        // Only gshare right, then a gshare miss restores history
        repeat (2) resolve(32'h0000_03c0, 32'h0000_0c00, 1'b1, 4'h0, 1'b1, 1'b0);
        fetch_pair(32'h0000_03c0, 32'h0000_0063, 32'h0000_0063, 2'b11);
        resolve(32'h0000_03c0, 32'h0000_0c00, 1'b1, 4'h5, 1'b0, 1'b1);
        fetch_pair(32'h0000_03c0, 32'h0000_0063, 32'h0000_0063, 2'b11);
        // Two jumps that both hit
        resolve(32'h0000_0700, 32'h0000_0e00, 1'b1, 4'h0, 1'b0, 1'b0);
        resolve(32'h0000_0704, 32'h0000_0f00, 1'b1, 4'h0, 1'b0, 1'b0);
        fetch_pair(32'h0000_0700, 32'h0000_006f, 32'h0000_006f, 2'b11);
        repeat (random_cycles) random_cycle();
        @(negedge clock);
        if_valid_i     = '0;
        ex_is_branch_i = '0;
        @(posedge clock);
        #1;
        assert (redirects > 0) else begin
            errors++;
            $display("The DUT never raised take_branch_o during the whole run");
        end
        $display("Redirect cycles: %0d, errors: %0d", redirects, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
